// File: filelist.f
verilog/flitPkg.sv
verilog/routePkg.sv
verilog/fifoView.sv
verilog/flitFifo4.sv
verilog/routeLookahead.sv
verilog/portCtrl.sv
verilog/outStage.sv
verilog/routerInPort.sv
test/routerInPortTb.sv

// File: run.sh
#!/bin/sh
# Build and run the router input port testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module routerInPortTb -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: pass"
  exit 0
fi
echo "run.sh: fail"
exit 1

// File: test/routerInPortTb.sv
module routerInPortTb;
  timeunit 1ns;
  timeprecision 100ps;
  import flitPkg::*;
  import routePkg::*;

  // Output port codes as seen on outPortSel
  localparam logic [2:0] portLocal = 3'd0;
  localparam logic [2:0] portEast  = 3'd1;
  localparam logic [2:0] portWest  = 3'd2;
  localparam logic [2:0] portNorth = 3'd3;
  localparam logic [2:0] portSouth = 3'd4;

  localparam int tableSize    = 22;
  localparam int fillCount    = 6;
  localparam int pushTimeout  = 200;
  localparam int drainTimeout = 500;

  typedef struct packed {
    logic [flitWidth-1:0] flit;
    logic [2:0]           port;
  } stimRow_t;

  // ********************
  // Stimulus table
  // ********************

  // Columns are the flit and its expected port
  // Router sits at (2,2)
  // Rows 0 to 5 fill the buffer and row 5 gets dropped
  localparam stimRow_t pktTable [tableSize] = '{
    {HEAD,   3'd5, 3'd2, 24'h00A001, portEast},
    {BODY,   30'h0A00_0002,          portEast},
    {BODY,   30'h0A00_0003,          portEast},
    {BODY,   30'h0A00_0004,          portEast},
    {TAIL,   30'h0A00_0005,          portEast},
    {SINGLE, 3'd2, 3'd2, 24'h00B006, portLocal},
    {SINGLE, 3'd2, 3'd2, 24'h00C007, portLocal},
    {HEAD,   3'd0, 3'd4, 24'h00C008, portWest},
    {BODY,   30'h0C00_0009,          portWest},
    {TAIL,   30'h0C00_000A,          portWest},
    {SINGLE, 3'd2, 3'd6, 24'h00C00B, portNorth},
    {SINGLE, 3'd2, 3'd0, 24'h00C00C, portSouth},
    {HEAD,   3'd3, 3'd0, 24'h00C00D, portEast},
    {TAIL,   30'h0C00_000E,          portEast},
    {HEAD,   3'd2, 3'd7, 24'h00C00F, portNorth},
    {BODY,   30'h0C00_0010,          portNorth},
    {TAIL,   30'h0C00_0011,          portNorth},
    {SINGLE, 3'd1, 3'd1, 24'h00C012, portWest},
    {HEAD,   3'd2, 3'd1, 24'h00C013, portSouth},
    {BODY,   30'h0C00_0014,          portSouth},
    {TAIL,   30'h0C00_0015,          portSouth},
    {SINGLE, 3'd7, 3'd7, 24'h00C016, portEast}
  };

  logic                 clk      = 1'b0;
  logic                 rstN     = 1'b0;
  logic [flitWidth-1:0] inFlit   = '0;
  logic                 inPush   = 1'b0;
  logic                 outReady = 1'b0;
  logic [flitWidth-1:0] outFlit;
  logic                 outValid;
  outPort_t             outPortSel;
  logic                 full;
  logic                 creditReturn;

  // Reference model
  logic [flitWidth-1:0] expFlits [$];
  logic [2:0]           expPorts [$];
  logic [2:0]           curPort = portLocal;

  int errCount       = 0;
  int timeoutCount   = 0;
  int creditCount    = 0;
  int deliveredCount = 0;

  // 0 holds outReady low, 1 holds it high, 2 takes it from the LFSR
  int          readyMode = 0;
  logic [31:0] lfsr      = 32'h11e0671e;

  logic                 wasStalled = 1'b0;
  logic [flitWidth-1:0] heldFlit;
  logic [2:0]           heldPort;
  logic [4:0]           portsSeen = '0;
  logic [flitWidth-1:0] wantFlit;
  logic [2:0]           wantPort;
  logic [typeWidth-1:0] gotType;

  routerInPort #(
    .myX (3'd2),
    .myY (3'd2)
  ) dut_i (
    .clk          (clk),
    .rstN         (rstN),
    .inFlit       (inFlit),
    .inPush       (inPush),
    .outReady     (outReady),
    .outFlit      (outFlit),
    .outValid     (outValid),
    .outPortSel   (outPortSel),
    .full         (full),
    .creditReturn (creditReturn)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // Galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  always @(posedge clk) begin
    if (readyMode == 2) begin
      outReady <= lfsr[0];
      lfsr     <= nextLfsr(lfsr);
    end else begin
      outReady <= (readyMode == 1);
    end
  end

  // Body and tail inherit the port of the last head
  function automatic void recordFlit(input stimRow_t row);
    logic [typeWidth-1:0] t;
    t = row.flit[typeLsb +: typeWidth];
    if (t == HEAD || t == SINGLE) begin
      curPort = row.port;
    end
    expFlits.push_back(row.flit);
    expPorts.push_back(curPort);
  endfunction

  // ********************
  // Output monitor
  // ********************

  always @(negedge clk) begin
    if (rstN) begin
      if (creditReturn) begin
        creditCount++;
      end
      if (wasStalled && (!outValid || outFlit !== heldFlit || outPortSel !== heldPort)) begin
        $display("ERR %0t: output changed while stalled", $time);
        errCount++;
      end
      // Transfer happens at the coming edge
      if (outValid && outReady) begin
        if (expFlits.size() == 0) begin
          $display("ERR %0t: unexpected flit %h", $time, outFlit);
          errCount++;
        end else begin
          wantFlit = expFlits.pop_front();
          wantPort = expPorts.pop_front();
          if (outFlit !== wantFlit) begin
            $display("ERR %0t: flit %h, expected %h", $time, outFlit, wantFlit);
            errCount++;
          end
          if (outPortSel !== wantPort) begin
            $display("ERR %0t: port %0d, expected %0d", $time, outPortSel, wantPort);
            errCount++;
          end
          gotType = wantFlit[typeLsb +: typeWidth];
          if (gotType == HEAD || gotType == SINGLE) begin
            portsSeen[wantPort] = 1'b1;
          end
          deliveredCount++;
        end
      end
      wasStalled = outValid && !outReady;
      heldFlit   = outFlit;
      heldPort   = outPortSel;
    end
  end

  // ********************
  // Driver tasks
  // ********************

  // Acceptance follows the full flag the DUT sees at the push edge
  task automatic pushFlit(input stimRow_t row, input bit waitFull);
    int waited;
    waited = 0;
    @(posedge clk);
    inFlit <= row.flit;
    inPush <= 1'b1;
    @(negedge clk);
    // Back off while full, then offer the same flit again
    while (waitFull && full && waited < pushTimeout) begin
      @(posedge clk);
      inPush <= 1'b0;
      @(negedge clk);
      waited++;
      if (!full) begin
        @(posedge clk);
        inPush <= 1'b1;
        @(negedge clk);
      end
    end
    if (!full) begin
      recordFlit(row);
    end else if (waitFull) begin
      $display("Timeout at %0t: buffer stayed full", $time);
      timeoutCount++;
    end
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (expFlits.size() != 0 && cycles < drainTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (expFlits.size() != 0) begin
      $display("Timeout at %0t: %0d flits never came out", $time, expFlits.size());
      timeoutCount++;
    end
  endtask

  // Stage plus four entries fill up and the sixth push is lost
  task automatic fillPhase();
    for (int i = 0; i < fillCount; i++) begin
      pushFlit(pktTable[i], 1'b0);
    end
    @(posedge clk);
    inPush <= 1'b0;
    @(negedge clk);
    if (!full || !outValid) begin
      $display("ERR %0t: full %b outValid %b after fill", $time, full, outValid);
      errCount++;
    end
    if (expFlits.size() != 5 || expFlits[4] !== pktTable[4].flit) begin
      $display("ERR %0t: %0d flits accepted, expected first 5", $time, expFlits.size());
      errCount++;
    end
    readyMode = 1;
    waitDrain();
    repeat (6) @(negedge clk);
    if (outValid || full) begin
      $display("ERR %0t: port not idle after drain", $time);
      errCount++;
    end
  endtask

  task automatic tablePhase();
    readyMode = 2;
    for (int i = fillCount; i < tableSize; i++) begin
      pushFlit(pktTable[i], 1'b1);
      if (timeoutCount != 0) begin
        return;
      end
    end
    @(posedge clk);
    inPush <= 1'b0;
    waitDrain();
    repeat (6) @(negedge clk);
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    if (outValid !== 1'b0 || creditReturn !== 1'b0 || full !== 1'b0) begin
      $display("ERR %0t: outputs not clear after reset", $time);
      errCount++;
    end
    fillPhase();
    if (timeoutCount == 0) begin
      tablePhase();
    end
    if (creditCount != deliveredCount) begin
      $display("ERR %0t: %0d credits for %0d flits", $time, creditCount, deliveredCount);
      errCount++;
    end
    if (timeoutCount == 0 && portsSeen != 5'b11111) begin
      $display("ERR %0t: ports seen %b, not all five", $time, portsSeen);
      errCount++;
    end
    $display("Errors: %0d value, %0d timeout", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/fifoView.sv
interface fifoView;
  import flitPkg::*;
  import routePkg::*;

  // Raw buffer contents
  logic [fifoDepth-1:0][flitWidth-1:0] entries;

  // One bit per occupied entry
  logic [fifoDepth-1:0] dValid;

  // Read pointer as it will be after the current pop
  logic [ptrWidth-1:0] dPtr;

  logic empty;

  // Buffer side
  modport src (output entries, dValid, dPtr, empty);

  // Lookahead side
  modport sink (input entries, dValid, dPtr);

endinterface

// File: verilog/flitFifo4.sv
module flitFifo4 (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [flitPkg::flitWidth-1:0] inData,
  input  logic                          push,
  input  logic                          pop,
  output logic [flitPkg::flitWidth-1:0] outData,
  output logic                          full,
  fifoView.src                          view
);
  import flitPkg::*;
  import routePkg::*;

  logic [fifoDepth-1:0][flitWidth-1:0] mem;

  logic [fifoDepth-1:0] valid;
  logic [fifoDepth-1:0] validNext;

  logic [ptrWidth-1:0] wrPtr;
  logic [ptrWidth-1:0] wrPtrNext;
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] rdPtrNext;

  logic empty;
  logic emptyNext;
  logic fullNext;

  // Accepted push, anything arriving while full is dropped
  logic pushOk;

  assign pushOk = push & ~full;

  // ********************
  // Pointers
  // ********************

  assign wrPtrNext = pushOk ? wrPtr + 1'b1 : wrPtr;
  assign rdPtrNext = pop ? rdPtr + 1'b1 : rdPtr;

  // ********************
  // Flags
  // ********************

  // Equal next pointers mean empty or full, the last event decides which
  always_comb begin
    emptyNext = empty;
    fullNext  = full;
    if (wrPtrNext != rdPtrNext) begin
      emptyNext = 1'b0;
      fullNext  = 1'b0;
    end else if (pop) begin
      emptyNext = 1'b1;
    end else if (pushOk) begin
      fullNext = 1'b1;
    end
  end

  // Per-entry occupancy
  always_comb begin
    validNext = valid;
    if (pushOk) begin
      validNext[wrPtr] = 1'b1;
    end
    if (pop) begin
      validNext[rdPtr] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
      valid <= '0;
    end else begin
      wrPtr <= wrPtrNext;
      rdPtr <= rdPtrNext;
      empty <= emptyNext;
      full  <= fullNext;
      valid <= validNext;
    end
  end

  // ********************
  // Storage
  // ********************

  always_ff @(posedge clk) begin
    if (pushOk) begin
      mem[wrPtr] <= inData;
    end
  end

  // Head of queue
  assign outData = mem[rdPtr];

  // Lookahead exposure
  assign view.entries = mem;
  assign view.dValid  = valid;
  assign view.dPtr    = rdPtrNext;
  assign view.empty   = empty;

endmodule

// File: verilog/flitPkg.sv
package flitPkg;

  // ********************
  // Flit layout
  // ********************

  localparam int flitWidth = 32;

  // Type field sits in the top two bits
  localparam int typeLsb   = 30;
  localparam int typeWidth = 2;

  // Destination fields, only meaningful in head and single flits
  localparam int destXLsb = 27;
  localparam int destYLsb = 24;

  typedef enum logic [typeWidth-1:0] {
    HEAD   = 2'b00,
    BODY   = 2'b01,
    TAIL   = 2'b10,
    SINGLE = 2'b11
  } flitType_t;

  function automatic flitType_t typeOf(input logic [flitWidth-1:0] flit);
    return flitType_t'(flit[typeLsb +: typeWidth]);
  endfunction

  // Carries a destination, opens a packet
  function automatic logic opensPacket(input flitType_t t);
    return (t == HEAD) || (t == SINGLE);
  endfunction

  // Last flit of a packet
  function automatic logic closesPacket(input flitType_t t);
    return (t == TAIL) || (t == SINGLE);
  endfunction

endpackage

// File: verilog/outStage.sv
module outStage (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          load,
  input  logic [flitPkg::flitWidth-1:0] inFlit,
  input  routePkg::outPort_t            inPort,
  input  logic                          outReady,
  output logic [flitPkg::flitWidth-1:0] outFlit,
  output routePkg::outPort_t            outPortSel,
  output logic                          outValid,
  output logic                          stageFree
);
  import flitPkg::*;
  import routePkg::*;

  // Room for a new flit now or after this cycle's handoff
  assign stageFree = ~outValid | outReady;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (load) begin
      outValid <= 1'b1;
    end else if (outReady) begin
      outValid <= 1'b0;
    end
  end

  // Data and port hold until replaced
  always_ff @(posedge clk) begin
    if (load) begin
      outFlit    <= inFlit;
      outPortSel <= inPort;
    end
  end

endmodule

// File: verilog/portCtrl.sv
module portCtrl (
  input  logic               clk,
  input  logic               rstN,
  input  logic               empty,
  input  flitPkg::flitType_t headFlitType,
  input  logic               routeValid,
  input  routePkg::outPort_t headRoute,
  input  logic               stageFree,
  output logic               pop,
  output logic               load,
  output routePkg::outPort_t sendPort,
  output logic               creditReturn
);
  import flitPkg::*;
  import routePkg::*;

  typedef enum logic {
    IDLE,
    FORWARD
  } ctrlState_t;

  ctrlState_t state;
  ctrlState_t stateNext;

  // Port held for the body of a multi-flit packet
  outPort_t pktPort;

  logic needRoute;
  logic startPkt;

  // ********************
  // Pop decision
  // ********************

  // Head and single flits wait for their lookahead route
  assign needRoute = opensPacket(headFlitType);

  assign pop = ~empty & stageFree & (~needRoute | routeValid);

  // Flit moves into the output stage in the same cycle
  assign load = pop;

  // One credit back upstream per freed entry
  assign creditReturn = pop;

  // Inside a packet the latched port wins
  assign sendPort = (state == FORWARD) ? pktPort : headRoute;

  // Multi-flit packet begins
  assign startPkt = pop & (headFlitType == HEAD);

  // ********************
  // Packet FSM
  // ********************

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (startPkt) begin
          stateNext = FORWARD;
        end
      end
      FORWARD: begin
        if (pop && closesPacket(headFlitType)) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk) begin
    if (startPkt) begin
      pktPort <= headRoute;
    end
  end

endmodule

// File: verilog/routeLookahead.sv
module routeLookahead #(
  parameter logic [routePkg::coordWidth-1:0] myX = '0,
  parameter logic [routePkg::coordWidth-1:0] myY = '0
) (
  input  logic               clk,
  input  logic               rstN,
  fifoView.sink              view,
  output routePkg::outPort_t headRoute,
  output logic               routeValid
);
  import flitPkg::*;
  import routePkg::*;

  logic [flitWidth-1:0]  nextFlit;
  logic                  nextValid;
  logic [coordWidth-1:0] destX;
  logic [coordWidth-1:0] destY;
  outPort_t              nextRoute;

  // Entry that becomes the head after this edge
  assign nextFlit  = view.entries[view.dPtr];
  assign nextValid = view.dValid[view.dPtr];

  assign destX = nextFlit[destXLsb +: coordWidth];
  assign destY = nextFlit[destYLsb +: coordWidth];

  // ********************
  // XY routing
  // ********************

  // X first, then Y, local when both match
  always_comb begin
    if (destX > myX) begin
      nextRoute = EAST;
    end else if (destX < myX) begin
      nextRoute = WEST;
    end else if (destY > myY) begin
      nextRoute = NORTH;
    end else if (destY < myY) begin
      nextRoute = SOUTH;
    end else begin
      nextRoute = LOCAL;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      routeValid <= 1'b0;
    end else begin
      routeValid <= nextValid;
    end
  end

  // Only trusted while routeValid is high
  always_ff @(posedge clk) begin
    headRoute <= nextRoute;
  end

endmodule

// File: verilog/routePkg.sv
package routePkg;

  // ********************
  // Mesh and port encoding
  // ********************

  // Width of one mesh coordinate
  localparam int coordWidth = 3;

  // Input buffer geometry
  localparam int fifoDepth = 4;
  localparam int ptrWidth  = 2;

  localparam int portWidth = 3;

  // Router output ports
  typedef enum logic [portWidth-1:0] {
    LOCAL = 3'd0,
    EAST  = 3'd1,
    WEST  = 3'd2,
    NORTH = 3'd3,
    SOUTH = 3'd4
  } outPort_t;

endpackage

// File: verilog/routerInPort.sv
module routerInPort #(
  parameter logic [routePkg::coordWidth-1:0] myX = '0,
  parameter logic [routePkg::coordWidth-1:0] myY = '0
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [flitPkg::flitWidth-1:0] inFlit,
  input  logic                          inPush,
  input  logic                          outReady,
  output logic [flitPkg::flitWidth-1:0] outFlit,
  output logic                          outValid,
  output routePkg::outPort_t            outPortSel,
  output logic                          full,
  output logic                          creditReturn
);
  import flitPkg::*;
  import routePkg::*;

  fifoView view ();

  logic [flitWidth-1:0] headFlit;
  logic                 pop;
  logic                 load;
  logic                 routeValid;
  logic                 stageFree;
  outPort_t             headRoute;
  outPort_t             sendPort;

  // ********************
  // Datapath
  // ********************

  flitFifo4 fifo_i (
    .clk     (clk),
    .rstN    (rstN),
    .inData  (inFlit),
    .push    (inPush),
    .pop     (pop),
    .outData (headFlit),
    .full    (full),
    .view    (view.src)
  );

  routeLookahead #(
    .myX (myX),
    .myY (myY)
  ) route_i (
    .clk        (clk),
    .rstN       (rstN),
    .view       (view.sink),
    .headRoute  (headRoute),
    .routeValid (routeValid)
  );

  portCtrl ctrl_i (
    .clk          (clk),
    .rstN         (rstN),
    .empty        (view.empty),
    .headFlitType (typeOf(headFlit)),
    .routeValid   (routeValid),
    .headRoute    (headRoute),
    .stageFree    (stageFree),
    .pop          (pop),
    .load         (load),
    .sendPort     (sendPort),
    .creditReturn (creditReturn)
  );

  outStage out_i (
    .clk        (clk),
    .rstN       (rstN),
    .load       (load),
    .inFlit     (headFlit),
    .inPort     (sendPort),
    .outReady   (outReady),
    .outFlit    (outFlit),
    .outPortSel (outPortSel),
    .outValid   (outValid),
    .stageFree  (stageFree)
  );

endmodule
